// File: design/div_consts.svh
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Operand, quotient and remainder width in bits.
`define DIV_DATA_WIDTH 32

// Width of the packed remainder and quotient pair.
`define DIV_DWORD_WIDTH (2 * `DIV_DATA_WIDTH)

// Cycles from the request cycle to the done cycle.
// Counts the operand stage and the result stage.
`define DIV_LATENCY 2

`endif

// File: design/div_pkg.sv
`include "div_consts.svh"

package div_pkg;

  // One machine word of the divide unit.
  // Dividend, divisor, quotient and remainder all use it.
  typedef logic [`DIV_DATA_WIDTH-1:0] data_t;

  // Remainder in the upper half, quotient in the lower half.
  typedef logic [`DIV_DWORD_WIDTH-1:0] dword_t;

endpackage

// File: design/cas_row.sv
`timescale 1ns/1ns
`include "div_consts.svh"

module cas_row
  import div_pkg::*;
(
  input  data_t op1,
  input  data_t op2,
  input  logic  add_sub_en_in,
  output logic  cout,
  output data_t divisor,
  output data_t rem
);

  // Carry chain, one bit per cell plus the row carry out.
  logic [`DIV_DATA_WIDTH:0] carry;
  data_t                    op2_eff;

  // Subtract is add of the inverted divisor with a carry in of one.
  assign op2_eff  = op2 ^ {`DIV_DATA_WIDTH{add_sub_en_in}};
  assign carry[0] = add_sub_en_in;

  // Each cell is a full adder on the conditionally inverted divisor bit.
  for (genvar j = 0; j < `DIV_DATA_WIDTH; j++) begin : g_cell
    assign rem[j]     = op1[j] ^ op2_eff[j] ^ carry[j];
    assign carry[j+1] = (op1[j] & op2_eff[j]) |
                        (op1[j] & carry[j]) |
                        (op2_eff[j] & carry[j]);
  end

  assign cout    = carry[`DIV_DATA_WIDTH];  // Row carry out.
  assign divisor = op2;                     // Passed down to the next row.

endmodule

// File: design/array_divider.sv
`timescale 1ns/1ns
`include "div_consts.svh"

module array_divider
  import div_pkg::*;
(
  input  data_t  operand_1,
  input  data_t  operand_2,
  output dword_t result
);

  localparam int width = `DIV_DATA_WIDTH;
  localparam int msb   = `DIV_DATA_WIDTH - 1;

  // Row links.
  data_t            row_op1 [width];
  data_t            row_div [width+1];
  data_t            row_rem [width];
  logic [width-1:0] row_add_sub;

  // Raw quotient bits from the rows.
  data_t            quo;

  logic             dvd_sign;
  logic             dvs_sign;
  logic             signs_differ;

  // Correction stage.
  data_t            final_rem;
  data_t            final_div;
  logic             rem_sign_ok;
  data_t            rem_restored;
  data_t            quo_adj;
  data_t            rem_minus_div;
  data_t            rem_plus_div;
  logic             sub_fix;
  logic             add_fix;
  data_t            rem_fixed;
  data_t            quo_fixed;

  assign dvd_sign     = operand_1[msb];
  assign dvs_sign     = operand_2[msb];
  assign signs_differ = dvd_sign ^ dvs_sign;

  // Row 0 starts from the sign extension of the dividend.
  assign row_div[0]     = operand_2;
  assign row_op1[0]     = {width{dvd_sign}};
  assign row_add_sub[0] = ~(dvd_sign ^ dvs_sign);  // Subtract on equal signs.

  // Shift the previous remainder left and bring in the next dividend bit.
  for (genvar i = 1; i < width; i++) begin : g_link
    assign row_op1[i]     = {row_rem[i-1][msb-1:0], operand_1[msb-i]};
    assign row_add_sub[i] = ~(row_rem[i-1][msb] ^ row_div[i][msb]);
  end

  // Row carries carry no information the correction needs.
  for (genvar i = 0; i < width; i++) begin : g_row
    cas_row u_cas_row (
      .op1          (row_op1[i]),
      .op2          (row_div[i]),
      .add_sub_en_in(row_add_sub[i]),
      .cout         (),
      .divisor      (row_div[i+1]),
      .rem          (row_rem[i])
    );
  end

  // Quotient MSB comes from row 0, LSB from the last row.
  for (genvar i = 0; i < width; i++) begin : g_quo
    assign quo[i] = ~(row_rem[msb-i][msb] ^ row_div[width-i][msb]);
  end

  assign final_rem = row_rem[width-1];
  assign final_div = row_div[width];

  // Remainder must carry the dividend's sign.
  assign rem_sign_ok = ~(final_rem[msb] ^ dvd_sign);

  always_comb begin
    if (rem_sign_ok) begin
      rem_restored = final_rem;
    end else if (signs_differ) begin
      rem_restored = final_rem - final_div;
    end else begin
      rem_restored = final_rem + final_div;
    end
  end

  // Truncate toward zero for a negative quotient.
  assign quo_adj = signs_differ ? quo + 1'b1 : quo;

  // A remainder of plus or minus the divisor is one step short.
  assign rem_minus_div = rem_restored - final_div;
  assign rem_plus_div  = rem_restored + final_div;
  assign sub_fix       = (rem_minus_div == '0);
  assign add_fix       = (rem_plus_div == '0);

  always_comb begin
    if (sub_fix) begin
      rem_fixed = '0;
      quo_fixed = quo_adj + 1'b1;  // Same signs, quotient grows.
    end else if (add_fix) begin
      rem_fixed = '0;
      quo_fixed = quo_adj - 1'b1;  // Opposite signs, quotient shrinks.
    end else begin
      rem_fixed = rem_restored;
      quo_fixed = quo_adj;
    end
  end

  assign result = {rem_fixed, quo_fixed};

endmodule

// File: design/div_unit.sv
`timescale 1ns/1ns
`include "div_consts.svh"

module div_unit
  import div_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  div_en,
  input  data_t operand_1,
  input  data_t operand_2,
  output logic  done,
  output data_t quotient,
  output data_t remainder,
  output logic  div_by_zero
);

  localparam data_t most_neg  = {1'b1, {(`DIV_DATA_WIDTH-1){1'b0}}};
  localparam data_t minus_one = '1;

  // One valid bit per pipeline stage.
  logic [`DIV_LATENCY-1:0] valid_pipe;

  // Stage 1 operands.
  data_t  dvd_q;
  data_t  dvs_q;

  dword_t array_result;
  data_t  array_quo;
  data_t  array_rem;

  logic   zero_divisor;
  logic   overflow;
  data_t  sel_quo;
  data_t  sel_rem;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`DIV_LATENCY-2:0], div_en};
    end
  end

  // Operands are captured only on a request.
  always_ff @(posedge clk) begin
    if (div_en) begin
      dvd_q <= operand_1;
      dvs_q <= operand_2;
    end
  end

  array_divider u_array_divider (
    .operand_1(dvd_q),
    .operand_2(dvs_q),
    .result   (array_result)
  );

  assign array_quo = array_result[`DIV_DATA_WIDTH-1:0];
  assign array_rem = array_result[`DIV_DWORD_WIDTH-1:`DIV_DATA_WIDTH];

  assign zero_divisor = (dvs_q == '0);
  assign overflow     = (dvd_q == most_neg) && (dvs_q == minus_one);

  // Cases the array cannot produce.
  always_comb begin
    if (zero_divisor) begin
      sel_quo = '1;
      sel_rem = dvd_q;
    end else if (overflow) begin
      sel_quo = most_neg;
      sel_rem = '0;
    end else begin
      sel_quo = array_quo;
      sel_rem = array_rem;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      quotient    <= '0;
      remainder   <= '0;
      div_by_zero <= 1'b0;
    end else begin
      div_by_zero <= valid_pipe[0] & zero_divisor;  // Only in the done cycle.
      if (valid_pipe[0]) begin
        quotient  <= sel_quo;
        remainder <= sel_rem;
      end
    end
  end

  assign done = valid_pipe[`DIV_LATENCY-1];  // Aligned with the result stage.

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/1ns

module clk_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Released on a falling edge, away from the sampling edge.
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// File: dv/div_unit_tb.sv
`timescale 1ns/1ns
`include "div_consts.svh"

module div_unit_tb
  import div_pkg::*;
();

  typedef struct packed {
    data_t dvd;
    data_t dvs;
    data_t quo;
    data_t rem;
    logic  dbz;
  } vec_t;

  localparam int num_directed   = 20;
  localparam int num_random     = 200;
  localparam int timeout_cycles = (num_directed + num_random) * (`DIV_LATENCY + 2) + 50;
  localparam data_t most_neg    = {1'b1, {(`DIV_DATA_WIDTH-1){1'b0}}};

  // Dividend, divisor, quotient, remainder, div_by_zero.
  vec_t directed [num_directed] = '{
    '{32'h0000_0007, 32'h0000_0002, 32'h0000_0003, 32'h0000_0001, 1'b0},
    '{32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD, 32'hFFFF_FFFF, 1'b0},
    '{32'h0000_0007, 32'hFFFF_FFFE, 32'hFFFF_FFFD, 32'h0000_0001, 1'b0},
    '{32'hFFFF_FFF9, 32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFF, 1'b0},
    '{32'h0000_0006, 32'h0000_0003, 32'h0000_0002, 32'h0000_0000, 1'b0},
    '{32'hFFFF_FFFA, 32'h0000_0003, 32'hFFFF_FFFE, 32'h0000_0000, 1'b0},
    '{32'h0000_0006, 32'hFFFF_FFFD, 32'hFFFF_FFFE, 32'h0000_0000, 1'b0},
    '{32'hFFFF_FFFA, 32'hFFFF_FFFD, 32'h0000_0002, 32'h0000_0000, 1'b0},
    '{32'h0000_0064, 32'h0000_0007, 32'h0000_000E, 32'h0000_0002, 1'b0},
    '{32'h0000_0000, 32'h0000_0005, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{32'h0000_0003, 32'h0000_0007, 32'h0000_0000, 32'h0000_0003, 1'b0},
    '{32'hFFFF_FFFD, 32'h0000_0007, 32'h0000_0000, 32'hFFFF_FFFD, 1'b0},
    '{32'h0000_3039, 32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_3039, 1'b1},
    '{32'hFFFF_FFFF, 32'h0000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1},
    '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_0000, 1'b0},
    '{32'h8000_0000, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000, 1'b0},
    '{32'h7FFF_FFFF, 32'h8000_0000, 32'h0000_0000, 32'h7FFF_FFFF, 1'b0},
    '{32'h8000_0000, 32'h8000_0000, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{32'h8000_0000, 32'h0000_0002, 32'hC000_0000, 32'h0000_0000, 1'b0},
    '{32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0001, 32'h0000_0000, 1'b0}
  };

  logic   clk;
  logic   arst_n;
  logic   div_en;
  data_t  operand_1;
  data_t  operand_2;
  logic   done;
  data_t  quotient;
  data_t  remainder;
  logic   div_by_zero;

  int     cycle_cnt = 0;
  int     tests_run = 0;
  int     pass_cnt  = 0;
  int     error_cnt = 0;
  integer seed      = 69;
  vec_t   exp_q[$];
  int     issue_q[$];  // Cycle in which each request was sampled.

  clk_gen #(.period_ns(20), .reset_cycles(8)) u_clk_gen (.clk(clk), .arst_n(arst_n));

  div_unit UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .div_en     (div_en),
    .operand_1  (operand_1),
    .operand_2  (operand_2),
    .done       (done),
    .quotient   (quotient),
    .remainder  (remainder),
    .div_by_zero(div_by_zero)
  );

  // Truncating signed division, special cases first.
  function automatic vec_t reference_divide(data_t dvd, data_t dvs);
    vec_t v;
    v.dvd = dvd;
    v.dvs = dvs;
    v.dbz = 1'b0;
    if (dvs == '0) begin
      v.quo = '1;
      v.rem = dvd;
      v.dbz = 1'b1;
    end else if (dvd == most_neg && dvs == '1) begin
      v.quo = most_neg;
      v.rem = '0;
    end else begin
      v.quo = $signed(dvd) / $signed(dvs);
      v.rem = $signed(dvd) % $signed(dvs);
    end
    return v;
  endfunction

  task automatic issue_request(input vec_t v);
    @(posedge clk);
    div_en    <= 1'b1;
    operand_1 <= v.dvd;
    operand_2 <= v.dvs;
    exp_q.push_back(v);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    div_en <= 1'b0;
  endtask

  task automatic check_reset_state();
    int errs;
    errs = 0;
    @(posedge clk);
    if (done !== 1'b0) begin
      $display("ERR done: got %h expected 0", done);
      errs++;
    end
    if (div_by_zero !== 1'b0) begin
      $display("ERR div_by_zero: got %h expected 0", div_by_zero);
      errs++;
    end
    if (quotient !== '0 || remainder !== '0) begin
      $display("ERR quotient/remainder: got %h/%h expected 0/0", quotient, remainder);
      errs++;
    end
    error_cnt += errs;
    $display("reset state %s", errs == 0 ? "ok" : "wrong");
  endtask

  always @(posedge clk) begin : monitor
    vec_t want;
    int   issued;
    int   errs;
    cycle_cnt = cycle_cnt + 1;
    if (div_en === 1'b1) begin
      issue_q.push_back(cycle_cnt);
    end
    if (done === 1'b1) begin
      if (exp_q.size() == 0 || issue_q.size() == 0) begin
        $display("done was raised with no request outstanding at cycle %0d", cycle_cnt);
        error_cnt++;
      end else begin
        want   = exp_q.pop_front();
        issued = issue_q.pop_front();
        errs   = 0;
        if (quotient !== want.quo) begin
          $display("ERR quotient: got %h expected %h", quotient, want.quo);
          errs++;
        end
        if (remainder !== want.rem) begin
          $display("ERR remainder: got %h expected %h", remainder, want.rem);
          errs++;
        end
        if (div_by_zero !== want.dbz) begin
          $display("ERR div_by_zero: got %h expected %h", div_by_zero, want.dbz);
          errs++;
        end
        if (cycle_cnt - issued != `DIV_LATENCY) begin
          $display("done came %0d cycles after the request instead of %0d",
                   cycle_cnt - issued, `DIV_LATENCY);
          errs++;
        end
        tests_run++;
        if (errs == 0) begin
          pass_cnt++;
        end
        error_cnt += errs;
        $display("test %0d %s: %h / %h -> quo %h rem %h", tests_run,
                 errs == 0 ? "ok" : "mismatch", want.dvd, want.dvs, quotient, remainder);
      end
    end else if (div_by_zero === 1'b1) begin
      $display("div_by_zero was high outside a done cycle at cycle %0d", cycle_cnt);
      error_cnt++;
    end
  end

  initial begin : watchdog
    wait (cycle_cnt >= timeout_cycles);
    $display("Timeout after %0d cycles with %0d results outstanding",
             cycle_cnt, exp_q.size());
    $display("%0d tests run, %0d passed, %0d errors", tests_run, pass_cnt, error_cnt);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    data_t dvd;
    data_t dvs;
    div_en    <= 1'b0;
    operand_1 <= '0;
    operand_2 <= '0;
    wait (arst_n === 1'b1);
    check_reset_state();

    // Table entries go in back to back.
    for (int i = 0; i < num_directed; i++) begin
      issue_request(directed[i]);
    end
    idle_cycle();

    for (int n = 0; n < num_random; n++) begin
      dvd = $random(seed);
      dvs = $random(seed);
      case (n % 8)
        0: dvs = $random(seed) % 4;  // Zero divisor now and then.
        1: begin
          dvd = most_neg;
          dvs = $random(seed) % 3;
        end
        2: dvd = $random(seed) % 1000;
        3: dvs = $random(seed) % 100;
        default: ;
      endcase
      issue_request(reference_divide(dvd, dvs));
      if ($random(seed) % 3 == 0) begin
        idle_cycle();
      end
    end
    idle_cycle();

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    $display("%0d tests run, %0d passed, %0d errors", tests_run, pass_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: div_unit.f
+incdir+design
design/div_pkg.sv
design/cas_row.sv
design/array_divider.sv
design/div_unit.sv
dv/clk_gen.sv
dv/div_unit_tb.sv

// File: Makefile
# Verilator build and run for the signed divide unit.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= div_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG) || [ $$rc -ne 0 ]; then \
	  echo "Result: failing, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Result: passing"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
